// File: source/socPkg.sv
/*
 * Shared widths, decode regions and UART states for the 16-bit memory subsystem.
 * Bus and address widths are fixed at 16; changing them also requires new
 * decode patterns in the memory controller.
 */

package socPkg;

	// Bus word and address widths
	localparam int dataBits = 16;
	localparam int addrBits = 16;

	// Register offset inside a 256-word peripheral window
	localparam int periphAddrBits = 8;

	// PWM LED outputs on pins 10..8
	localparam int pwmChannels = 3;

	// Decode targets of the memory map
	typedef enum logic [2:0] {
		regionRom,
		regionUart,
		regionGpio,
		regionPwm,
		regionRam,
		regionNone
	} region_e;

	// 8N1 transmitter states
	typedef enum logic [1:0] {
		uartIdle,
		uartStart,
		uartData,
		uartStop
	} uartState_e;

endpackage

// File: source/periphBus.sv
/*
 * Register bus from the memory controller to one peripheral.
 * wrN is active low and held high while the peripheral is not selected.
 * rdata is combinational from the peripheral registers.
 */

interface periphBus;

	logic [socPkg::periphAddrBits-1:0] offset;
	logic [socPkg::dataBits-1:0] wdata;
	logic [socPkg::dataBits-1:0] rdata;
	logic wrN;

	// Controller side drives address, data and strobe
	modport controller(output offset, wdata, wrN, input rdata);

	// Peripheral side answers with read data
	modport peripheral(input offset, wdata, wrN, output rdata);

endinterface

// File: source/memoryController.sv
/*
 * Address decode, write strobe steering and read-data mux.
 * Map: ROM 0x0000-0x0FFF, UART 0x1000-0x10FF, GPIO 0x1100-0x11FF,
 * PWM 0x1200-0x12FF, RAM 0x8000-0xFFFF; anything else reads zero.
 * Writes to ROM and unmapped space are dropped.
 * Every read has one cycle of latency; addr must be held for it.
 */

module memoryController (
	input  logic CLK,
	input  logic rst,
	input  logic [socPkg::addrBits-1:0] addr,
	input  logic [socPkg::dataBits-1:0] dataIn,
	output logic [socPkg::dataBits-1:0] dataOut,
	input  logic wrN,
	output logic [11:0] romAddr,
	input  logic [socPkg::dataBits-1:0] romData,
	output logic [14:0] ramAddr,
	input  logic [socPkg::dataBits-1:0] ramData,
	output logic ramWrN,
	periphBus.controller uartBus,
	periphBus.controller gpioBus,
	periphBus.controller pwmBus
);

	socPkg::region_e region;

	// Peripheral read data, registered to line up with ROM/RAM latency
	logic [socPkg::dataBits-1:0] periphNext;
	logic [socPkg::dataBits-1:0] periphRead;

	// Region decode from the current address
	always_comb begin
		casez (addr)
			16'b0000_????_????_????: region = socPkg::regionRom;
			16'h10??: region = socPkg::regionUart;
			16'h11??: region = socPkg::regionGpio;
			16'h12??: region = socPkg::regionPwm;
			16'b1???_????_????_????: region = socPkg::regionRam;
			default: region = socPkg::regionNone;
		endcase
	end

	// Memories see the low address bits directly
	assign romAddr = addr[11:0];
	assign ramAddr = addr[14:0];

	// Offset and data fan out to all peripherals, only the strobe is steered
	assign uartBus.offset = addr[socPkg::periphAddrBits-1:0];
	assign gpioBus.offset = addr[socPkg::periphAddrBits-1:0];
	assign pwmBus.offset = addr[socPkg::periphAddrBits-1:0];
	assign uartBus.wdata = dataIn;
	assign gpioBus.wdata = dataIn;
	assign pwmBus.wdata = dataIn;

	// Write strobes, high unless the region is selected
	always_comb begin
		ramWrN = 1'b1;
		uartBus.wrN = 1'b1;
		gpioBus.wrN = 1'b1;
		pwmBus.wrN = 1'b1;
		periphNext = '0;
		case (region)
			socPkg::regionUart: begin
				uartBus.wrN = wrN;
				periphNext = uartBus.rdata;
			end
			socPkg::regionGpio: begin
				gpioBus.wrN = wrN;
				periphNext = gpioBus.rdata;
			end
			socPkg::regionPwm: begin
				pwmBus.wrN = wrN;
				periphNext = pwmBus.rdata;
			end
			socPkg::regionRam: ramWrN = wrN;
			// ROM and unmapped space take no writes
			default: ;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			periphRead <= '0;
		end else begin
			periphRead <= periphNext;
		end
	end

	// Final source picked on the current address
	always_comb begin
		case (region)
			socPkg::regionRom: dataOut = romData;
			socPkg::regionRam: dataOut = ramData;
			default: dataOut = periphRead;
		endcase
	end

endmodule

// File: source/bootRom.sv
/*
 * 4k x 16 boot ROM with registered read.
 * Contents come from source/bootImage.hex, path relative to the run directory.
 * Words past the end of the image read as zero.
 */

module bootRom (
	input  logic CLK,
	input  logic [11:0] addr,
	output logic [socPkg::dataBits-1:0] data
);

	localparam int romWords = 4096;

	logic [socPkg::dataBits-1:0] mem [romWords];

	// Clear first so a short image leaves zeros behind it
	initial begin
		for (int i = 0; i < romWords; i++) begin
			mem[i] = '0;
		end
		$readmemh("source/bootImage.hex", mem);
	end

	always_ff @(posedge CLK) begin
		data <= mem[addr];
	end

endmodule

// File: source/programRam.sv
/*
 * 32k x 16 single-port program RAM.
 * Write at the edge where wrN is low; the read port is registered and
 * returns the old word during a write to the same address.
 * No reset, contents are undefined until written.
 */

module programRam (
	input  logic CLK,
	input  logic [14:0] addr,
	input  logic [socPkg::dataBits-1:0] wdata,
	output logic [socPkg::dataBits-1:0] rdata,
	input  logic wrN
);

	localparam int ramWords = 32768;

	logic [socPkg::dataBits-1:0] mem [ramWords];

	always_ff @(posedge CLK) begin
		// Active-low strobe from the controller
		if (!wrN) begin
			mem[addr] <= wdata;
		end
		rdata <= mem[addr];
	end

endmodule

// File: source/gpioPort.sv
/*
 * 8-bit GPIO output port.
 * Offset 0 holds the output byte, read back zero-extended.
 * Other offsets read zero and ignore writes.
 */

module gpioPort (
	input  logic CLK,
	input  logic rst,
	periphBus.peripheral bus,
	output logic [7:0] gpio
);

	logic [7:0] outReg;
	logic sel;

	// Only offset 0 is decoded
	assign sel = (bus.offset == '0);

	always_ff @(posedge CLK) begin
		if (rst) begin
			outReg <= '0;
		end else if (!bus.wrN && sel) begin
			// Low byte of the bus word only
			outReg <= bus.wdata[7:0];
		end
	end

	assign gpio = outReg;

	// Read-back path
	assign bus.rdata = sel ? {{(socPkg::dataBits - 8){1'b0}}, outReg} : '0;

endmodule

// File: source/pwmLed.sv
/*
 * Three-channel PWM LED driver.
 * Offsets 0..2 hold 8-bit duty values, written and read back zero-extended.
 * An output is high while the shared 8-bit counter is below its duty,
 * so duty 0 stays off and duty 255 is off for one cycle in 256.
 */

module pwmLed (
	input  logic CLK,
	input  logic rst,
	periphBus.peripheral bus,
	output logic [socPkg::pwmChannels-1:0] led
);

	logic [7:0] duty [socPkg::pwmChannels];

	// Free-running, wraps every 256 cycles
	logic [7:0] counter;

	always_ff @(posedge CLK) begin
		if (rst) begin
			counter <= '0;
			for (int i = 0; i < socPkg::pwmChannels; i++) begin
				duty[i] <= '0;
			end
		end else begin
			counter <= counter + 8'd1;
			for (int i = 0; i < socPkg::pwmChannels; i++) begin
				// Duty write for the matching offset
				if (!bus.wrN && bus.offset == socPkg::periphAddrBits'(i)) begin
					duty[i] <= bus.wdata[7:0];
				end
			end
		end
	end

	// Comparators, one per channel
	always_comb begin
		for (int i = 0; i < socPkg::pwmChannels; i++) begin
			led[i] = (counter < duty[i]);
		end
	end

	// Read-back, offsets past the last channel read zero
	always_comb begin
		bus.rdata = '0;
		for (int i = 0; i < socPkg::pwmChannels; i++) begin
			if (bus.offset == socPkg::periphAddrBits'(i)) begin
				bus.rdata = {{(socPkg::dataBits - 8){1'b0}}, duty[i]};
			end
		end
	end

endmodule

// File: source/uartTx.sv
/*
 * 8N1 UART transmitter without receive, parity or interrupts.
 * A byte written to offset 0 starts a frame unless one is in flight.
 * Offset 1 reads busy in bit 0.
 * Bit period is clkFreq / baudRate cycles rounded down.
 */

module uartTx #(
	parameter int clkFreq = 25000000,
	parameter int baudRate = 1562500
) (
	input  logic CLK,
	input  logic rst,
	periphBus.peripheral bus,
	output logic txd
);

	localparam int bitCycles = clkFreq / baudRate;
	localparam int cntBits = (bitCycles > 1) ? $clog2(bitCycles) : 1;

	socPkg::uartState_e state;
	logic [cntBits-1:0] bitCnt;
	logic [2:0] bitIdx;
	logic [7:0] shiftData;
	logic bitDone;
	logic busy;

	// Last cycle of the current bit period
	assign bitDone = (bitCnt == cntBits'(bitCycles - 1));
	assign busy = (state != socPkg::uartIdle);

	always_ff @(posedge CLK) begin
		if (rst) begin
			state <= socPkg::uartIdle;
			bitCnt <= '0;
			bitIdx <= '0;
		end else begin
			// Period counter runs only inside a frame
			if (state == socPkg::uartIdle || bitDone) begin
				bitCnt <= '0;
			end else begin
				bitCnt <= bitCnt + cntBits'(1);
			end
			case (state)
				socPkg::uartIdle: begin
					if (!bus.wrN && bus.offset == '0) begin
						state <= socPkg::uartStart;
					end
				end
				socPkg::uartStart: begin
					if (bitDone) begin
						state <= socPkg::uartData;
						bitIdx <= '0;
					end
				end
				socPkg::uartData: begin
					if (bitDone) begin
						// Eight data bits sent LSB first
						if (bitIdx == 3'd7) begin
							state <= socPkg::uartStop;
						end
						bitIdx <= bitIdx + 3'd1;
					end
				end
				socPkg::uartStop: begin
					if (bitDone) begin
						state <= socPkg::uartIdle;
					end
				end
				default: state <= socPkg::uartIdle;
			endcase
		end
	end

	// Byte latch loads only from idle
	always_ff @(posedge CLK) begin
		if (state == socPkg::uartIdle && !bus.wrN && bus.offset == '0) begin
			shiftData <= bus.wdata[7:0];
		end
	end

	// Line level from the state
	always_comb begin
		case (state)
			socPkg::uartStart: txd = 1'b0;
			socPkg::uartData: txd = shiftData[bitIdx];
			default: txd = 1'b1;
		endcase
	end

	// Status at offset 1
	assign bus.rdata = (bus.offset == socPkg::periphAddrBits'(1)) ?
		{{(socPkg::dataBits - 1){1'b0}}, busy} : '0;

endmodule

// File: source/socTop.sv
/*
 * Memory subsystem top level.
 * Pins: 7..0 GPIO, 10..8 PWM, 14..11 tied low, 15 UART transmit.
 * Bus master holds addr, dataIn and wrN across the sampling edge.
 */

module socTop #(
	parameter int clkFreq = 25000000,
	parameter int baudRate = 1562500
) (
	input  logic CLK,
	input  logic rst,
	input  logic [socPkg::addrBits-1:0] addr,
	input  logic [socPkg::dataBits-1:0] dataIn,
	output logic [socPkg::dataBits-1:0] dataOut,
	input  logic wrN,
	output wire [15:0] pins
);

	logic [11:0] romAddr;
	logic [socPkg::dataBits-1:0] romData;
	logic [14:0] ramAddr;
	logic [socPkg::dataBits-1:0] ramData;
	logic ramWrN;

	// One register bus per peripheral
	periphBus uartBus ();
	periphBus gpioBus ();
	periphBus pwmBus ();

	memoryController ctrl0 (
		.CLK(CLK),
		.rst(rst),
		.addr(addr),
		.dataIn(dataIn),
		.dataOut(dataOut),
		.wrN(wrN),
		.romAddr(romAddr),
		.romData(romData),
		.ramAddr(ramAddr),
		.ramData(ramData),
		.ramWrN(ramWrN),
		.uartBus(uartBus.controller),
		.gpioBus(gpioBus.controller),
		.pwmBus(pwmBus.controller)
	);

	bootRom rom0 (.CLK(CLK), .addr(romAddr), .data(romData));

	// RAM write data straight from the master
	programRam ram0 (
		.CLK(CLK),
		.addr(ramAddr),
		.wdata(dataIn),
		.rdata(ramData),
		.wrN(ramWrN)
	);

	gpioPort gpio0 (.CLK(CLK), .rst(rst), .bus(gpioBus.peripheral), .gpio(pins[7:0]));

	pwmLed pwm0 (.CLK(CLK), .rst(rst), .bus(pwmBus.peripheral), .led(pins[10:8]));

	uartTx #(
		.clkFreq(clkFreq),
		.baudRate(baudRate)
	) uart0 (
		.CLK(CLK),
		.rst(rst),
		.bus(uartBus.peripheral),
		.txd(pins[15])
	);

	// Reserved pins
	assign pins[14:11] = 4'b0000;

endmodule

// File: tb/socTb.sv
/*
 * Testbench for socTop driven line by line from tb/socStim.txt.
 * Run from the project root so the stimulus and boot image paths resolve.
 * Bus inputs change on the rising edge and outputs are sampled on the falling edge.
 * UART bit timing assumes the DUT keeps its default clkFreq and baudRate.
 */

module socTb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int clkFreq = 25000000;
	localparam int baudRate = 1562500;
	localparam int bitPeriod = clkFreq / baudRate;
	localparam int fallTimeout = 4 * bitPeriod;
	localparam int idlePolls = 64;

	logic CLK;
	logic rst;
	logic [15:0] addr;
	logic [15:0] dataIn;
	logic [15:0] dataOut;
	logic wrN;
	wire [15:0] pins;

	int checks;
	int mismatches;
	int timeouts;
	int otherErrors;

	socTop dut0 (
		.CLK(CLK),
		.rst(rst),
		.addr(addr),
		.dataIn(dataIn),
		.dataOut(dataOut),
		.wrN(wrN),
		.pins(pins)
	);

	// 40 ns clock
	always #20 CLK = ~CLK;

	task automatic reportMismatch(input logic [8*32-1:0] name, input logic [15:0] expVal,
		input logic [15:0] actVal);
		mismatches++;
		$display("FAIL %0s: expected %h, actual %h", name, expVal, actVal);
	endtask

	task automatic busWrite(input logic [15:0] a, input logic [15:0] v);
		@(posedge CLK);
		addr <= a;
		dataIn <= v;
		wrN <= 1'b0;
		// Write takes effect on this edge
		@(posedge CLK);
		wrN <= 1'b1;
	endtask

	// Sample mid-cycle after the one-cycle read latency
	task automatic busRead(input logic [15:0] a, output logic [15:0] d);
		@(posedge CLK);
		addr <= a;
		wrN <= 1'b1;
		@(posedge CLK);
		@(negedge CLK);
		d = dataOut;
	endtask

	task automatic runPwm(input logic [8*32-1:0] name, input int ch, input logic [15:0] duty);
		logic [15:0] readBack;
		int highCount;
		busWrite(16'h1200 + 16'(ch), duty);
		busRead(16'h1200 + 16'(ch), readBack);
		checks++;
		if (readBack !== duty) begin
			reportMismatch(name, duty, readBack);
		end
		// Any 256-cycle window covers one full PWM period
		highCount = 0;
		repeat (256) begin
			@(negedge CLK);
			if (pins[8 + ch]) begin
				highCount++;
			end
		end
		checks++;
		if (highCount != int'(duty[7:0])) begin
			reportMismatch(name, duty, 16'(highCount));
		end
	endtask

	task automatic decodeFrame(input logic [8*32-1:0] name, input logic [7:0] expByte);
		int waitCnt;
		logic [7:0] gotByte;
		waitCnt = 0;
		gotByte = '0;
		do begin
			@(negedge CLK);
			waitCnt++;
		end while (pins[15] && waitCnt < fallTimeout);
		if (pins[15]) begin
			timeouts++;
			$display("TIMEOUT %0s: UART line never dropped for a start bit", name);
			return;
		end
		// Middle of the start bit
		repeat (bitPeriod / 2 - 1) @(negedge CLK);
		checks++;
		if (pins[15] !== 1'b0) begin
			reportMismatch(name, 16'h0000, {15'b0, pins[15]});
		end
		// Data bits go LSB first
		for (int i = 0; i < 8; i++) begin
			repeat (bitPeriod) @(negedge CLK);
			gotByte[i] = pins[15];
		end
		checks++;
		if (gotByte !== expByte) begin
			reportMismatch(name, {8'h00, expByte}, {8'h00, gotByte});
		end
		// Middle of the stop bit
		repeat (bitPeriod) @(negedge CLK);
		checks++;
		if (pins[15] !== 1'b1) begin
			reportMismatch(name, 16'h0001, {15'b0, pins[15]});
		end
	endtask

	task automatic busyAndRetry(input logic [8*32-1:0] name, input logic [7:0] byteVal);
		logic [15:0] status;
		busRead(16'h1001, status);
		checks++;
		if (status !== 16'h0001) begin
			reportMismatch(name, 16'h0001, status);
		end
		// Write while busy is dropped and the frame keeps the first byte
		busWrite(16'h1000, {8'h00, ~byteVal});
	endtask

	task automatic runUart(input logic [8*32-1:0] name, input logic [7:0] byteVal);
		logic [15:0] status;
		logic sawLow;
		int polls;
		busWrite(16'h1000, {8'h00, byteVal});
		fork
			decodeFrame(name, byteVal);
			busyAndRetry(name, byteVal);
		join
		// Poll status until busy clears
		polls = 0;
		status = 16'h0001;
		while (status[0] && polls < idlePolls) begin
			busRead(16'h1001, status);
			polls++;
		end
		checks++;
		if (status[0]) begin
			timeouts++;
			$display("TIMEOUT %0s: UART busy flag never cleared", name);
		end else if (status !== 16'h0000) begin
			reportMismatch(name, 16'h0000, status);
		end
		// Line stays idle for longer than a frame
		sawLow = 1'b0;
		repeat (12 * bitPeriod) begin
			@(negedge CLK);
			if (!pins[15]) begin
				sawLow = 1'b1;
			end
		end
		checks++;
		if (sawLow) begin
			mismatches++;
			$display("ERROR %0s: an extra UART frame followed the ignored write", name);
		end
	endtask

	initial begin
		int fd;
		int n;
		int ch;
		logic done;
		logic [7:0] op;
		logic [15:0] a;
		logic [15:0] v;
		logic [15:0] got;
		logic [8*32-1:0] name;
		CLK = 1'b0;
		rst = 1'b1;
		addr = '0;
		dataIn = '0;
		wrN = 1'b1;
		checks = 0;
		mismatches = 0;
		timeouts = 0;
		otherErrors = 0;
		done = 1'b0;
		repeat (16) @(posedge CLK);
		rst <= 1'b0;
		fd = $fopen("tb/socStim.txt", "r");
		if (fd == 0) begin
			otherErrors++;
			$display("ERROR: could not open tb/socStim.txt");
			done = 1'b1;
		end
		while (!done) begin
			n = $fscanf(fd, " %c", op);
			if (n != 1) begin
				done = 1'b1;
			end else if (op == "#") begin
				// Skip the rest of a comment line
				do begin
					ch = $fgetc(fd);
				end while (ch != int'("\n") && ch != -1);
			end else begin
				n = $fscanf(fd, "%h %h %s", a, v, name);
				if (n != 3) begin
					otherErrors++;
					$display("ERROR: malformed stimulus line for op %c", op);
					done = 1'b1;
				end else begin
					case (op)
						"W": busWrite(a, v);
						"R": begin
							busRead(a, got);
							checks++;
							if (got !== v) begin
								reportMismatch(name, v, got);
							end
						end
						// Address column is the pin mask
						"G": begin
							@(negedge CLK);
							checks++;
							if ((pins & a) !== v) begin
								reportMismatch(name, v, pins & a);
							end
						end
						"P": runPwm(name, int'(a), v);
						"U": runUart(name, v[7:0]);
						default: begin
							otherErrors++;
							$display("ERROR: unknown stimulus op %c", op);
						end
					endcase
				end
			end
		end
		if (fd != 0) begin
			$fclose(fd);
		end
		$display("Summary: %0d checks, %0d mismatches, %0d timeouts, %0d other errors",
			checks, mismatches, timeouts, otherErrors);
		if (mismatches + timeouts + otherErrors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// File: source/bootImage.hex
// Boot ROM image, one 16-bit word per line starting at address 0x000
7C00
1234
A5A5
5A5A
0F0F
BEEF
CAFE
8001
00FF
FF00
1357
2468
DEAD
4C21
9E37

// File: tb/socStim.txt
# op addr value name; W write, R read and expect value, G pins masked by addr equal value
# P pwm channel in addr and duty in value, U uart byte in value (addr unused)
G FFFF 8000 resetPins
R 1001 0000 resetUartStatus
R 1100 0000 resetGpio
R 0000 7C00 romWord0
R 0001 1234 romWord1
R 0005 BEEF romWord5
R 000E 9E37 romWord14
R 0ABC 0000 romPastImage
W 0005 0000 romWriteAttempt
R 0005 BEEF romAfterWrite
R 2000 0000 unmapped2000
R 4000 0000 unmapped4000
W 4000 FFFF unmappedWrite
R 4000 0000 unmappedAfterWrite
W 1100 1234 gpioWrite
G 00FF 0034 gpioPins
R 1100 0034 gpioReadBack
R 1101 0000 gpioOtherOffset
W 8000 1111 ramLowWrite
W FFFF 2222 ramHighWrite
W C123 3C3C ramMidWrite
W 9100 00AA ramAliasGpio
W 9200 00FF ramAliasPwm
R 8000 1111 ramLowRead
R FFFF 2222 ramHighRead
R C123 3C3C ramMidRead
R 9100 00AA ramAliasRead
R 1100 0034 gpioAfterRam
R 1200 0000 pwmAfterRam
G FFFF 8034 pinsAfterRam
P 0 0080 pwmCh0Half
P 1 0000 pwmCh1Zero
P 2 00FF pwmCh2Full
P 1 0001 pwmCh1One
U 0 00A5 uartA5
U 0 003C uart3C

// File: compile.f
source/socPkg.sv
source/periphBus.sv
source/memoryController.sv
source/bootRom.sv
source/programRam.sv
source/gpioPort.sv
source/pwmLed.sv
source/uartTx.sv
source/socTop.sv
tb/socTb.sv

// File: Makefile
# Verilator build and run for the socTop memory subsystem
# Run from the project root, the testbench reads tb/ and source/ data files

VERILATOR ?= verilator
TOP ?= socTb
OBJDIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -j 0

FILELIST := compile.f
SOURCES := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
BIN := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuild only when a listed source or the file list changes
$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -qF '*** FAILED ***' $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -qF '*** PASSED ***' $(LOG) || { echo "No pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJDIR) $(LOG)
